// ==== design/inflight_pkg.sv ====
package inflight_pkg;

  // physical register file is 64 entries
  localparam int REG_ADDR_W = 6;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // source operand lookup
  typedef struct packed {
    reg_addr_t addr;
    logic      const_op;
  } lookup_req_t;

  // completion or allocation of one register
  typedef struct packed {
    reg_addr_t addr;
    logic      valid;
  } reg_write_t;

  // post-reset clearing sequence
  typedef enum logic {
    INIT_SWEEP = 1'b0,
    INIT_IDLE  = 1'b1
  } init_state_t;

endpackage

// ==== design/inflight_bank.sv ====
`timescale 1ns/1ns

module inflight_bank
  import inflight_pkg::*;
#(
  parameter int NUM_READ = 4,
  parameter int NUM_DONE = 2,
  parameter int NUM_BANKS = 2,
  parameter int BANK_INDEX = 0,
  localparam int SEL_W = $clog2(NUM_BANKS),
  localparam int OFF_W = REG_ADDR_W - SEL_W
)
(
  input  logic                          clk,
  input  reg_addr_t [NUM_READ-1:0]      lookup_addr,
  input  reg_write_t [NUM_DONE-1:0]     done,
  input  reg_write_t                    alloc,
  input  logic [OFF_W-1:0]              sweep_addr,
  input  logic                          sweep_en,
  output logic [NUM_READ-1:0]           bank_bit
);

  localparam int DEPTH = (1 << REG_ADDR_W) / NUM_BANKS;

  logic [DEPTH-1:0]    flags;
  logic [NUM_DONE-1:0] done_valid;

  // low address bits pick the bank
  function automatic logic in_bank(reg_addr_t addr);
    return (int'(addr) % NUM_BANKS) == BANK_INDEX;
  endfunction

  function automatic logic [OFF_W-1:0] offset(reg_addr_t addr);
    return OFF_W'(addr >> SEL_W);
  endfunction

  // later assignments win, so alloc overrides a clear to the same entry
  always_ff @(posedge clk)
  begin
    if (sweep_en)
    begin
      flags[sweep_addr] <= 1'b0;
    end
    for (int i = 0; i < NUM_DONE; i++)
    begin
      if (done[i].valid && in_bank(done[i].addr))
      begin
        flags[offset(done[i].addr)] <= 1'b0;
      end
    end
    if (alloc.valid && in_bank(alloc.addr))
    begin
      flags[offset(alloc.addr)] <= 1'b1;
    end
  end

  // out-of-bank addresses return 0 so the port can OR all banks
  always_comb
  begin
    for (int p = 0; p < NUM_READ; p++)
    begin
      if (in_bank(lookup_addr[p]))
        bank_bit[p] = flags[offset(lookup_addr[p])];
      else
        bank_bit[p] = 1'b0;
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_DONE; i++)
    begin
      done_valid[i] = done[i].valid;
    end
  end

  // no core writes while the init sweep owns the storage
  a_sweep_no_write: assert property (
    @(posedge clk) sweep_en |-> !alloc.valid && (done_valid == '0)
  ) else $error("inflight_bank %0d: write during init sweep", BANK_INDEX);

endmodule

// ==== design/inflight_init.sv ====
`timescale 1ns/1ns

module inflight_init
  import inflight_pkg::*;
#(
  parameter int NUM_BANKS = 2,
  localparam int OFF_W = REG_ADDR_W - $clog2(NUM_BANKS)
)
(
  input  logic             clk,
  input  logic             rst,
  output logic [OFF_W-1:0] sweep_addr,
  output logic             sweep_en,
  output logic             init_busy
);

  localparam int DEPTH = (1 << REG_ADDR_W) / NUM_BANKS;
  localparam logic [OFF_W-1:0] LAST_OFF = OFF_W'(DEPTH - 1);

  init_state_t state;

  // one offset per cycle, every bank in parallel
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= INIT_SWEEP;
      sweep_addr <= '0;
    end
    else if (state == INIT_SWEEP)
    begin
      sweep_addr <= sweep_addr + 1'b1;
      if (sweep_addr == LAST_OFF)
      begin
        state <= INIT_IDLE;
      end
    end
  end

  assign init_busy = (state == INIT_SWEEP);
  assign sweep_en  = init_busy;

  // once idle, only a reset restarts the sweep
  a_init_once: assert property (
    @(posedge clk) disable iff (rst) !init_busy |=> !init_busy
  ) else $error("inflight_init: init_busy rose without reset");

endmodule

// ==== design/inflight_port.sv ====
`timescale 1ns/1ns

module inflight_port
  import inflight_pkg::*;
#(
  parameter int NUM_BANKS = 2,
  parameter int NUM_DONE = 2
)
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_en,
  input  lookup_req_t               req,
  input  logic                      init_busy,
  input  logic [NUM_BANKS-1:0]      bank_bit,
  input  reg_write_t [NUM_DONE-1:0] done,
  input  reg_write_t                alloc,
  output reg_addr_t                 lookup_addr,
  output logic                      busy
);

  logic const_q;
  logic blocked_q;
  logic stored;
  logic hit_done;
  logic hit_alloc;

  // request held while read_en is low
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lookup_addr <= '0;
      const_q     <= 1'b0;
      blocked_q   <= 1'b0;
    end
    else if (read_en)
    begin
      lookup_addr <= req.addr;
      const_q     <= req.const_op;
      blocked_q   <= init_busy;
    end
  end

  // only one bank can return a set bit
  assign stored = |bank_bit;

  // writes in the result cycle land at the next edge, so bypass them here
  always_comb
  begin
    hit_done = 1'b0;
    for (int i = 0; i < NUM_DONE; i++)
    begin
      if (done[i].valid && (done[i].addr == lookup_addr))
        hit_done = 1'b1;
    end
  end

  assign hit_alloc = alloc.valid && (alloc.addr == lookup_addr);

  // alloc beats done on the same register
  assign busy = !const_q && !blocked_q && (hit_alloc || (stored && !hit_done));

  // a constant operand never reads as pending in the next cycle
  a_const_not_busy: assert property (
    @(posedge clk) disable iff (rst) (read_en && req.const_op) |=> !busy
  ) else $error("inflight_port: busy set for constant operand");

endmodule

// ==== design/inflight_table.sv ====
`timescale 1ns/1ns

module inflight_table
  import inflight_pkg::*;
#(
  parameter int NUM_READ = 4,
  parameter int NUM_DONE = 2,
  parameter int NUM_BANKS = 2,
  localparam int OFF_W = REG_ADDR_W - $clog2(NUM_BANKS)
)
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       read_en,
  input  lookup_req_t [NUM_READ-1:0] lookup,
  input  reg_write_t [NUM_DONE-1:0]  done,
  input  reg_write_t                 alloc,
  output logic [NUM_READ-1:0]        busy,
  output logic                       init_busy
);

  reg_addr_t [NUM_READ-1:0]                 lookup_addr;
  logic [NUM_BANKS-1:0][NUM_READ-1:0]       bank_bits;
  logic [NUM_READ-1:0][NUM_BANKS-1:0]       port_bits;
  logic [OFF_W-1:0]                         sweep_addr;
  logic                                     sweep_en;

  inflight_init #(
    .NUM_BANKS (NUM_BANKS)
  ) u_init (
    .clk        (clk),
    .rst        (rst),
    .sweep_addr (sweep_addr),
    .sweep_en   (sweep_en),
    .init_busy  (init_busy)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    inflight_bank #(
      .NUM_READ   (NUM_READ),
      .NUM_DONE   (NUM_DONE),
      .NUM_BANKS  (NUM_BANKS),
      .BANK_INDEX (b)
    ) u_bank (
      .clk         (clk),
      .lookup_addr (lookup_addr),
      .done        (done),
      .alloc       (alloc),
      .sweep_addr  (sweep_addr),
      .sweep_en    (sweep_en),
      .bank_bit    (bank_bits[b])
    );
  end

  for (genvar p = 0; p < NUM_READ; p++)
  begin : g_port
    // regroup bank outputs per port
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bit
      assign port_bits[p][b] = bank_bits[b][p];
    end

    inflight_port #(
      .NUM_BANKS (NUM_BANKS),
      .NUM_DONE  (NUM_DONE)
    ) u_port (
      .clk         (clk),
      .rst         (rst),
      .read_en     (read_en),
      .req         (lookup[p]),
      .init_busy   (init_busy),
      .bank_bit    (port_bits[p]),
      .done        (done),
      .alloc       (alloc),
      .lookup_addr (lookup_addr[p]),
      .busy        (busy[p])
    );
  end

endmodule

// ==== bench/inflight_model.svh ====
// shadow scoreboard, one flag per physical register
logic                 shadow [64];
reg_addr_t            req_addr [NUM_READ];
logic [NUM_READ-1:0]  req_const;
logic [NUM_READ-1:0]  req_blocked;
int                   init_left = 0;
logic [31:0]          lfsr_state = 32'hc417_3848;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// state change at a rising edge, from the inputs driven in the cycle before
task automatic model_edge();
  if (rst)
  begin
    foreach (shadow[i])
      shadow[i] = 1'b0;
    foreach (req_addr[p])
      req_addr[p] = '0;
    req_const   = '0;
    req_blocked = '0;
    init_left   = INIT_CYCLES;
  end
  else
  begin
    // clears first, then the allocation
    for (int i = 0; i < NUM_DONE; i++)
    begin
      if (done[i].valid)
        shadow[done[i].addr] = 1'b0;
    end
    if (alloc.valid)
      shadow[alloc.addr] = 1'b1;
    if (read_en)
    begin
      for (int p = 0; p < NUM_READ; p++)
      begin
        req_addr[p]    = lookup[p].addr;
        req_const[p]   = lookup[p].const_op;
        req_blocked[p] = (init_left > 0);
      end
    end
    if (init_left > 0)
      init_left = init_left - 1;
  end
endtask

// expected outputs for the current cycle, writes of this cycle bypassed
task automatic predict();
  logic hit_alloc;
  logic hit_done;
  for (int p = 0; p < NUM_READ; p++)
  begin
    hit_alloc = alloc.valid && (alloc.addr == req_addr[p]);
    hit_done  = 1'b0;
    for (int i = 0; i < NUM_DONE; i++)
    begin
      if (done[i].valid && (done[i].addr == req_addr[p]))
        hit_done = 1'b1;
    end
    if (req_const[p] || req_blocked[p])
      exp_busy[p] = 1'b0;
    else if (hit_alloc)
      exp_busy[p] = 1'b1;
    else if (hit_done)
      exp_busy[p] = 1'b0;
    else
      exp_busy[p] = shadow[req_addr[p]];
  end
  exp_init = (init_left > 0);
endtask

// ==== bench/inflight_table_tb.sv ====
`timescale 1ns/1ns

module inflight_table_tb
  import inflight_pkg::*;
();

  localparam int NUM_READ = 4;
  localparam int NUM_DONE = 2;
  localparam int NUM_BANKS = 2;
  localparam int PERIOD = 40;
  localparam int INIT_CYCLES = 64 / NUM_BANKS;
  localparam int RANDOM_CYCLES = 300;
  // two resets with init, directed sections with some slack, random mix
  localparam int TOTAL_CYCLES = 2 * (2 + INIT_CYCLES) + 130 + RANDOM_CYCLES;

  logic                       clk;
  logic                       rst;
  logic                       read_en;
  lookup_req_t [NUM_READ-1:0] lookup;
  reg_write_t [NUM_DONE-1:0]  done;
  reg_write_t                 alloc;
  logic [NUM_READ-1:0]        busy;
  logic                       init_busy;

  logic [NUM_READ-1:0]        exp_busy;
  logic                       exp_init;
  logic                       check_on;
  int                         busy_errors = 0;
  int                         init_errors = 0;

  `include "inflight_model.svh"

  inflight_table #(
    .NUM_READ  (NUM_READ),
    .NUM_DONE  (NUM_DONE),
    .NUM_BANKS (NUM_BANKS)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .lookup    (lookup),
    .done      (done),
    .alloc     (alloc),
    .busy      (busy),
    .init_busy (init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(2 * TOTAL_CYCLES * PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  a_busy_match: assert property (
    @(posedge clk) disable iff (rst) check_on |-> busy == exp_busy
  ) else
  begin
    busy_errors = busy_errors + 1;
    $display("FAILED at %0t: busy %b, expected %b", $time, $sampled(busy),
             $sampled(exp_busy));
  end

  a_init_match: assert property (
    @(posedge clk) disable iff (rst) check_on |-> init_busy == exp_init
  ) else
  begin
    init_errors = init_errors + 1;
    $display("FAILED at %0t: init_busy %b, expected %b", $time, $sampled(init_busy),
             $sampled(exp_init));
  end

  // idle cycle; lookups change but read_en is low so they are ignored
  task automatic begin_cycle();
    @(posedge clk);
    model_edge();
    #2;
    read_en = 1'b0;
    done    = '0;
    alloc   = '0;
    for (int p = 0; p < NUM_READ; p++)
    begin
      lookup[p].addr     = reg_addr_t'(rand_bits(6));
      lookup[p].const_op = lfsr_bit();
    end
    predict();
  endtask

  task automatic alloc_reg(input reg_addr_t r);
    begin_cycle();
    alloc = '{addr: r, valid: 1'b1};
    predict();
  endtask

  task automatic done_reg(input reg_addr_t r, input int port);
    begin_cycle();
    done[port] = '{addr: r, valid: 1'b1};
    predict();
  endtask

  task automatic write_both(input reg_addr_t r);
    begin_cycle();
    alloc   = '{addr: r, valid: 1'b1};
    done[1] = '{addr: r, valid: 1'b1};
    predict();
  endtask

  task automatic look_all(input reg_addr_t r, input logic [NUM_READ-1:0] const_mask);
    begin_cycle();
    read_en = 1'b1;
    for (int p = 0; p < NUM_READ; p++)
      lookup[p] = '{addr: r, const_op: const_mask[p]};
    predict();
  endtask

  // narrow address range in the mix so that bypass hits are frequent
  task automatic random_cycle(input logic writes);
    begin_cycle();
    read_en = writes ? (rand_bits(2) != 32'd0) : 1'b1;
    for (int p = 0; p < NUM_READ; p++)
    begin
      lookup[p].addr     = reg_addr_t'(rand_bits(writes ? 4 : 6));
      lookup[p].const_op = (rand_bits(3) == 32'd7);
    end
    if (writes)
    begin
      for (int i = 0; i < NUM_DONE; i++)
      begin
        done[i].valid = lfsr_bit();
        done[i].addr  = reg_addr_t'(rand_bits(4));
      end
      alloc.valid = lfsr_bit();
      alloc.addr  = reg_addr_t'(rand_bits(4));
    end
    predict();
  endtask

  initial
  begin
    rst      = 1'b1;
    read_en  = 1'b0;
    lookup   = '0;
    done     = '0;
    alloc    = '0;
    check_on = 1'b0;
    exp_busy = '0;
    exp_init = 1'b1;
    repeat (2) begin_cycle();
    rst      = 1'b0;
    check_on = 1'b1;
    predict();

    // lookups during the init sweep
    repeat (INIT_CYCLES) random_cycle(1'b0);

    // allocate, look up, complete, look up again; spread over both banks
    for (int k = 0; k < 8; k++)
    begin
      alloc_reg(reg_addr_t'(k * 9));
      look_all(reg_addr_t'(k * 9), 4'b0000);
      begin_cycle();
      done_reg(reg_addr_t'(k * 9), k % 2);
      look_all(reg_addr_t'(k * 9), 4'b0000);
      begin_cycle();
    end

    // writes landing in the result cycle
    for (int k = 0; k < 2; k++)
    begin
      look_all(reg_addr_t'(20 + k), 4'b0000);
      alloc_reg(reg_addr_t'(20 + k));
      look_all(reg_addr_t'(20 + k), 4'b0000);
      done_reg(reg_addr_t'(20 + k), k);
      look_all(reg_addr_t'(20 + k), 4'b0000);
      write_both(reg_addr_t'(20 + k));
      done_reg(reg_addr_t'(20 + k), 0);
    end

    // constant operand on ports 1 and 3 only
    for (int k = 0; k < 2; k++)
    begin
      alloc_reg(reg_addr_t'(40 + k));
      look_all(reg_addr_t'(40 + k), 4'b1010);
      begin_cycle();
      done_reg(reg_addr_t'(40 + k), 1);
    end

    // held lookup follows writes while read_en stays low
    look_all(reg_addr_t'(33), 4'b0000);
    repeat (2) begin_cycle();
    alloc_reg(reg_addr_t'(33));
    repeat (2) begin_cycle();
    done_reg(reg_addr_t'(33), 1);
    repeat (2) begin_cycle();

    repeat (RANDOM_CYCLES) random_cycle(1'b1);

    // register 63 left pending across a second reset
    // its offset is the last one the sweep clears
    alloc_reg(reg_addr_t'(63));
    begin_cycle();
    rst = 1'b1;
    repeat (2) begin_cycle();
    rst = 1'b0;
    predict();
    repeat (INIT_CYCLES) look_all(reg_addr_t'(63), 4'b0000);

    begin_cycle();
    @(posedge clk);
    #1;
    $display("busy errors: %0d, init_busy errors: %0d", busy_errors, init_errors);
    if (busy_errors + init_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+bench
design/inflight_pkg.sv
design/inflight_bank.sv
design/inflight_init.sv
design/inflight_port.sv
design/inflight_table.sv
bench/inflight_table_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module inflight_table_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  && ! grep -q "CHECKS FAILED" sim.log \
  && grep -q "ALL CHECKS PASSED" sim.log \
  || { echo "simulation failed"; exit 1; }
